// ==== hw/mem_cfg_pkg.sv ====
package mem_cfg_pkg;

    //////////////////////////////////////////////////////////////////////
    // word geometry

    localparam int WORD_WIDTH   = 32;                       // bits per memory word
    localparam int COL_WIDTH    = 8;                        // one byte column
    localparam int NUM_COL      = WORD_WIDTH / COL_WIDTH;   // 4 columns per word
    localparam int OFFSET_WIDTH = $clog2(NUM_COL);          // byte offset bits, 2

    // 14 index bits -> 16K words, 64KB
    localparam int DEFAULT_INDEX_WIDTH = 14;

    // byte address width as seen at the lane ports
    localparam int ADDR_WIDTH = 32;

    //////////////////////////////////////////////////////////////////////
    // vector types

    // full data word, column 0 in the low byte
    typedef logic [WORD_WIDTH-1:0] word_t;

    // per column write enable, bit c -> column c
    typedef logic [NUM_COL-1:0] byte_en_t;

    // byte position inside a word
    typedef logic [OFFSET_WIDTH-1:0] offset_t;

    // raw byte address, upper bits beyond the index wrap
    typedef logic [ADDR_WIDTH-1:0] addr_t;

endpackage

// ==== hw/mem_op_pkg.sv ====
package mem_op_pkg;

    //////////////////////////////////////////////////////////////////////
    // access size
    //
    // same encoding for loads and stores, low two bits of funct3
    // code 3 is not an access, a store writes nothing and a load
    // returns zero

    typedef logic [1:0] mem_size_t;

    localparam mem_size_t SIZE_BYTE = 2'd0;   // lb / lbu / sb
    localparam mem_size_t SIZE_HALF = 2'd1;   // lh / lhu / sh, offset 0 or 2
    localparam mem_size_t SIZE_WORD = 2'd2;   // lw / sw, offset 0 only

    //////////////////////////////////////////////////////////////////////
    // request description
    //
    // a load lane: address, size, sign flag, read strobe
    //   sign high -> sign extend, low -> zero extend
    // a store lane: address, data, size, write level
    //   data is right aligned, only the low byte or half is used
    //   for sub word sizes
    //
    // no request spans two words

endpackage

// ==== hw/store_align.sv ====
`timescale 1ns/10ps

module store_align #(
    parameter int INDEX_WIDTH = mem_cfg_pkg::DEFAULT_INDEX_WIDTH
) (
    input  mem_cfg_pkg::addr_t      st_addr,
    input  mem_cfg_pkg::word_t      st_data,
    input  mem_op_pkg::mem_size_t   st_size,
    input  logic                    st_write,
    output logic [INDEX_WIDTH-1:0]  wr_index,
    output mem_cfg_pkg::byte_en_t   wr_en,
    output mem_cfg_pkg::word_t      wr_data
);

    localparam int COL_W  = mem_cfg_pkg::COL_WIDTH;
    localparam int HALF_W = 2 * COL_W;
    localparam int OFS_W  = mem_cfg_pkg::OFFSET_WIDTH;
    localparam int N_COL  = mem_cfg_pkg::NUM_COL;

    mem_cfg_pkg::offset_t  offset;      // byte within the word
    mem_cfg_pkg::byte_en_t size_en;     // enables from size and offset only

    //////////////////////////////////////////////////////////////////////
    // address split

    assign offset   = st_addr[OFS_W-1:0];
    assign wr_index = st_addr[INDEX_WIDTH+OFS_W-1:OFS_W];   // upper bits dropped, wraps

    //////////////////////////////////////////////////////////////////////
    // enables and lane replication
    //
    // the low byte / half is copied into every column position, the
    // enables then pick which copy lands in the array

    always_comb
    begin
        size_en = '0;
        wr_data = st_data;                                  // word store, as is
        case (st_size)
            mem_op_pkg::SIZE_BYTE:
            begin
                size_en = mem_cfg_pkg::byte_en_t'(1) << offset;
                wr_data = {N_COL{st_data[COL_W-1:0]}};      // byte in all 4 columns
            end
            mem_op_pkg::SIZE_HALF:
            begin
                if (!offset[0])                             // offset 0 or 2 only
                    size_en = mem_cfg_pkg::byte_en_t'(3) << offset;
                wr_data = {(N_COL/2){st_data[HALF_W-1:0]}}; // half in both halves
            end
            mem_op_pkg::SIZE_WORD:
            begin
                if (offset == '0)
                    size_en = '1;
            end
            default:
            begin
                size_en = '0;                               // code 3, no write
            end
        endcase
    end

    // write level gates everything
    assign wr_en = st_write ? size_en : '0;

endmodule

// ==== hw/data_array.sv ====
`timescale 1ns/10ps

module data_array #(
    parameter int INDEX_WIDTH = mem_cfg_pkg::DEFAULT_INDEX_WIDTH
) (
    input  logic                    MEM_CLK,
    // write port 0, store lane 0
    input  logic [INDEX_WIDTH-1:0]  wr_index_0,
    input  mem_cfg_pkg::byte_en_t   wr_en_0,
    input  mem_cfg_pkg::word_t      wr_data_0,
    // write port 1, store lane 1
    input  logic [INDEX_WIDTH-1:0]  wr_index_1,
    input  mem_cfg_pkg::byte_en_t   wr_en_1,
    input  mem_cfg_pkg::word_t      wr_data_1,
    // read ports, one per load lane
    input  logic [INDEX_WIDTH-1:0]  rd_index_0,
    input  logic [INDEX_WIDTH-1:0]  rd_index_1,
    input  logic                    rd_en_0,
    input  logic                    rd_en_1,
    output mem_cfg_pkg::word_t      rd_word_0,
    output mem_cfg_pkg::word_t      rd_word_1
);

    localparam int DEPTH = 2 ** INDEX_WIDTH;
    localparam int COL_W = mem_cfg_pkg::COL_WIDTH;
    localparam int N_COL = mem_cfg_pkg::NUM_COL;

    mem_cfg_pkg::word_t memory [0:DEPTH-1];     // 16K x 32 by default

    logic                  same_word;   // both stores hit one word
    mem_cfg_pkg::byte_en_t en_0_kept;   // port 0 columns that port 1 does not write

    //////////////////////////////////////////////////////////////////////
    // write merge
    //
    // both ports land in the same edge. on a shared word the
    // columns are merged, lane 1 owns any column both lanes enable

    assign same_word = (wr_index_0 == wr_index_1);
    assign en_0_kept = same_word ? (wr_en_0 & ~wr_en_1) : wr_en_0;

    always_ff @(posedge MEM_CLK)
    begin
        for (int c = 0; c < N_COL; c++)
        begin
            if (en_0_kept[c])
                memory[wr_index_0][c*COL_W +: COL_W] <= wr_data_0[c*COL_W +: COL_W];
            if (wr_en_1[c])
                memory[wr_index_1][c*COL_W +: COL_W] <= wr_data_1[c*COL_W +: COL_W];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read ports
    //
    // registered, one cycle latency
    // a read in the same edge as a write to that word sees the old word

    always_ff @(posedge MEM_CLK)
    begin
        if (rd_en_0)
            rd_word_0 <= memory[rd_index_0];    // held until next strobe
    end

    always_ff @(posedge MEM_CLK)
    begin
        if (rd_en_1)
            rd_word_1 <= memory[rd_index_1];
    end

endmodule

// ==== hw/load_extract.sv ====
`timescale 1ns/10ps

module load_extract (
    input  logic                    MEM_CLK,
    input  logic                    rst_n,
    // load request
    input  mem_cfg_pkg::addr_t      ld_addr,
    input  mem_op_pkg::mem_size_t   ld_size,
    input  logic                    ld_sign,
    input  logic                    ld_read,
    // word from the array read port, one cycle after ld_read
    input  mem_cfg_pkg::word_t      rd_word,
    // result
    output mem_cfg_pkg::word_t      ld_data,
    output logic                    ld_valid
);

    localparam int WORD_W = mem_cfg_pkg::WORD_WIDTH;
    localparam int COL_W  = mem_cfg_pkg::COL_WIDTH;
    localparam int HALF_W = 2 * COL_W;
    localparam int OFS_W  = mem_cfg_pkg::OFFSET_WIDTH;

    mem_cfg_pkg::offset_t   offset_q;   // byte offset of the request
    mem_op_pkg::mem_size_t  size_q;
    logic                   sign_q;     // 1 = sign extend
    logic                   valid_q;    // ld_read, one cycle late

    logic [COL_W-1:0]       byte_sel;   // addressed column
    logic [HALF_W-1:0]      half_sel;   // addressed half, low or high

    //////////////////////////////////////////////////////////////////////
    // request capture

    always_ff @(posedge MEM_CLK)
    begin
        if (ld_read)
        begin
            offset_q <= ld_addr[OFS_W-1:0];
            size_q   <= ld_size;
            sign_q   <= ld_sign;
        end
    end

    always_ff @(posedge MEM_CLK or negedge rst_n)
    begin
        if (!rst_n)
            valid_q <= 1'b0;
        else
            valid_q <= ld_read;         // one pulse per strobe
    end

    //////////////////////////////////////////////////////////////////////
    // slice and extend

    assign byte_sel = rd_word[offset_q*COL_W +: COL_W];
    assign half_sel = rd_word[offset_q[1]*HALF_W +: HALF_W];   // offset bit 0 checked below

    always_comb
    begin
        ld_data = '0;                   // misaligned / bad size -> zero
        case (size_q)
            mem_op_pkg::SIZE_BYTE:
            begin
                ld_data = {{(WORD_W-COL_W){sign_q & byte_sel[COL_W-1]}}, byte_sel};
            end
            mem_op_pkg::SIZE_HALF:
            begin
                if (!offset_q[0])
                    ld_data = {{(WORD_W-HALF_W){sign_q & half_sel[HALF_W-1]}}, half_sel};
            end
            mem_op_pkg::SIZE_WORD:
            begin
                if (offset_q == '0)
                    ld_data = rd_word;  // sign flag has no effect
            end
            default:
            begin
                ld_data = '0;
            end
        endcase
    end

    assign ld_valid = valid_q;

endmodule

// ==== hw/lsu_data_mem.sv ====
`timescale 1ns/10ps

module lsu_data_mem #(
    parameter int INDEX_WIDTH = mem_cfg_pkg::DEFAULT_INDEX_WIDTH
) (
    input  logic                    MEM_CLK,
    input  logic                    rst_n,
    // load lane 0
    input  mem_cfg_pkg::addr_t      ld0_addr,
    input  mem_op_pkg::mem_size_t   ld0_size,
    input  logic                    ld0_sign,
    input  logic                    ld0_read,
    output mem_cfg_pkg::word_t      ld0_data,
    output logic                    ld0_valid,
    // load lane 1
    input  mem_cfg_pkg::addr_t      ld1_addr,
    input  mem_op_pkg::mem_size_t   ld1_size,
    input  logic                    ld1_sign,
    input  logic                    ld1_read,
    output mem_cfg_pkg::word_t      ld1_data,
    output logic                    ld1_valid,
    // store lane 0
    input  mem_cfg_pkg::addr_t      st0_addr,
    input  mem_cfg_pkg::word_t      st0_data,
    input  mem_op_pkg::mem_size_t   st0_size,
    input  logic                    st0_write,
    // store lane 1, wins on shared bytes
    input  mem_cfg_pkg::addr_t      st1_addr,
    input  mem_cfg_pkg::word_t      st1_data,
    input  mem_op_pkg::mem_size_t   st1_size,
    input  logic                    st1_write
);

    localparam int OFS_W = mem_cfg_pkg::OFFSET_WIDTH;

    // aligned store requests into the array
    logic [INDEX_WIDTH-1:0]  wr_index_0;
    logic [INDEX_WIDTH-1:0]  wr_index_1;
    mem_cfg_pkg::byte_en_t   wr_en_0;
    mem_cfg_pkg::byte_en_t   wr_en_1;
    mem_cfg_pkg::word_t      wr_data_0;
    mem_cfg_pkg::word_t      wr_data_1;

    // read side
    logic [INDEX_WIDTH-1:0]  rd_index_0;
    logic [INDEX_WIDTH-1:0]  rd_index_1;
    mem_cfg_pkg::word_t      rd_word_0;
    mem_cfg_pkg::word_t      rd_word_1;

    assign rd_index_0 = ld0_addr[INDEX_WIDTH+OFS_W-1:OFS_W];   // word index, wraps
    assign rd_index_1 = ld1_addr[INDEX_WIDTH+OFS_W-1:OFS_W];

    //////////////////////////////////////////////////////////////////////
    // store path

    store_align #(.INDEX_WIDTH(INDEX_WIDTH)) u_st_align_0 (
        .st_addr  (st0_addr),
        .st_data  (st0_data),
        .st_size  (st0_size),
        .st_write (st0_write),
        .wr_index (wr_index_0),
        .wr_en    (wr_en_0),
        .wr_data  (wr_data_0)
    );

    store_align #(.INDEX_WIDTH(INDEX_WIDTH)) u_st_align_1 (
        .st_addr  (st1_addr),
        .st_data  (st1_data),
        .st_size  (st1_size),
        .st_write (st1_write),
        .wr_index (wr_index_1),
        .wr_en    (wr_en_1),
        .wr_data  (wr_data_1)
    );

    //////////////////////////////////////////////////////////////////////
    // shared word array

    data_array #(.INDEX_WIDTH(INDEX_WIDTH)) u_array (
        .MEM_CLK    (MEM_CLK),
        .wr_index_0 (wr_index_0),
        .wr_en_0    (wr_en_0),
        .wr_data_0  (wr_data_0),
        .wr_index_1 (wr_index_1),
        .wr_en_1    (wr_en_1),
        .wr_data_1  (wr_data_1),
        .rd_index_0 (rd_index_0),
        .rd_index_1 (rd_index_1),
        .rd_en_0    (ld0_read),         // strobe doubles as read enable
        .rd_en_1    (ld1_read),
        .rd_word_0  (rd_word_0),
        .rd_word_1  (rd_word_1)
    );

    //////////////////////////////////////////////////////////////////////
    // load path

    load_extract u_ld_extract_0 (
        .MEM_CLK  (MEM_CLK),
        .rst_n    (rst_n),
        .ld_addr  (ld0_addr),
        .ld_size  (ld0_size),
        .ld_sign  (ld0_sign),
        .ld_read  (ld0_read),
        .rd_word  (rd_word_0),
        .ld_data  (ld0_data),
        .ld_valid (ld0_valid)
    );

    load_extract u_ld_extract_1 (
        .MEM_CLK  (MEM_CLK),
        .rst_n    (rst_n),
        .ld_addr  (ld1_addr),
        .ld_size  (ld1_size),
        .ld_sign  (ld1_sign),
        .ld_read  (ld1_read),
        .rd_word  (rd_word_1),
        .ld_data  (ld1_data),
        .ld_valid (ld1_valid)
    );

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic MEM_CLK,
    output logic rst_n
);

    // free running clock, first rising edge at half a period
    initial
    begin
        MEM_CLK = 1'b0;
        forever
            #(PERIOD_NS / 2) MEM_CLK = ~MEM_CLK;
    end

    initial
    begin
        rst_n = 1'b0;                           // low from time zero
        repeat (RESET_CYCLES) @(posedge MEM_CLK);
        #2 rst_n = 1'b1;                        // released off the edge
    end

endmodule

// ==== bench/tb_lsu_data_mem.sv ====
`timescale 1ns/10ps

module tb_lsu_data_mem;

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 16;
    localparam int DRIVE_DELAY     = 2;        // ns after the rising edge
    localparam int CYCLES_PER_LINE = 40;       // watchdog budget per access
    localparam int DRAIN_CYCLES    = 8;        // wait for the last results
    localparam int SEED            = 37598;
    localparam     STIM_FILE       = "bench/lsu_stimulus.txt";

    // op column of the stimulus file
    localparam int OP_LOAD   = 0;
    localparam int OP_STORE  = 1;
    localparam int OP_FILLER = 2;              // word store with random data

    logic MEM_CLK;
    logic rst_n;

    mem_cfg_pkg::addr_t    ld0_addr, ld1_addr, st0_addr, st1_addr;
    mem_op_pkg::mem_size_t ld0_size, ld1_size, st0_size, st1_size;
    logic                  ld0_sign, ld1_sign;
    logic                  ld0_read, ld1_read, st0_write, st1_write;
    mem_cfg_pkg::word_t    st0_data, st1_data;
    mem_cfg_pkg::word_t    ld0_data, ld1_data;
    logic                  ld0_valid, ld1_valid;

    // one entry per stimulus access
    int                    grp_q[$];
    int                    lane_q[$];
    int                    op_q[$];
    mem_op_pkg::mem_size_t size_q[$];
    logic                  sign_q[$];
    mem_cfg_pkg::addr_t    addr_q[$];
    mem_cfg_pkg::word_t    data_q[$];     // store data or expected load result

    // loads in flight in issue order per lane
    mem_cfg_pkg::word_t    exp0_q[$];
    mem_cfg_pkg::word_t    exp1_q[$];
    mem_cfg_pkg::addr_t    where0_q[$];
    mem_cfg_pkg::addr_t    where1_q[$];

    logic read_seen_0;                    // ld0_read at the last rising edge
    logic read_seen_1;
    bit   loaded;                         // arms the watchdog once the stimulus is read

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clk_gen (
        .MEM_CLK (MEM_CLK),
        .rst_n   (rst_n)
    );

    lsu_data_mem #(.INDEX_WIDTH(mem_cfg_pkg::DEFAULT_INDEX_WIDTH)) DUT (
        .MEM_CLK   (MEM_CLK),   .rst_n     (rst_n),
        .ld0_addr  (ld0_addr),  .ld0_size  (ld0_size),  .ld0_sign  (ld0_sign),
        .ld0_read  (ld0_read),  .ld0_data  (ld0_data),  .ld0_valid (ld0_valid),
        .ld1_addr  (ld1_addr),  .ld1_size  (ld1_size),  .ld1_sign  (ld1_sign),
        .ld1_read  (ld1_read),  .ld1_data  (ld1_data),  .ld1_valid (ld1_valid),
        .st0_addr  (st0_addr),  .st0_data  (st0_data),  .st0_size  (st0_size),
        .st0_write (st0_write),
        .st1_addr  (st1_addr),  .st1_data  (st1_data),  .st1_size  (st1_size),
        .st1_write (st1_write)
    );

    //////////////////////////////////////////////////////////////////////
    // reporting

    task automatic fail_and_stop();
        $display("tests failed");
        $fatal(1, "run stopped at %0t ns", $time);
    endtask

    task automatic check_value(input mem_cfg_pkg::word_t actual,
                               input mem_cfg_pkg::word_t expected, input string what);
        if (actual !== expected)
        begin
            $display("[ERROR] %0t ns %s: got %08h, expected %08h",
                     $time, what, actual, expected);
            fail_and_stop();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus file

    task automatic load_stimulus();
        int                 fd;
        int                 n;
        int                 g, ln, op, sz, sg;
        mem_cfg_pkg::addr_t a;
        mem_cfg_pkg::word_t d;
        logic [8*160-1:0]   skip;           // rest of a comment line
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0)
        begin
            $display("cannot open the stimulus file %s", STIM_FILE);
            fail_and_stop();
        end
        while (!$feof(fd))
        begin
            n = $fscanf(fd, "%d %d %d %d %d %h %h\n", g, ln, op, sz, sg, a, d);
            if (n == 7 && ln >= 0 && ln <= 1 &&
                (op == OP_LOAD || op == OP_STORE || op == OP_FILLER))
            begin
                grp_q.push_back(g);
                lane_q.push_back(ln);
                op_q.push_back(op);
                size_q.push_back(mem_op_pkg::mem_size_t'(sz));
                sign_q.push_back(sg != 0);
                addr_q.push_back(a);
                data_q.push_back(d);
            end
            else if (n > 0)
            begin
                $display("malformed stimulus line after access %0d", grp_q.size());
                fail_and_stop();
            end
            else
                n = $fgets(skip, fd);       // comment or blank line
        end
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////////////////////////
    // driving

    task automatic drive_idle();
        ld0_addr  = '0;
        ld0_size  = '0;
        ld0_sign  = 1'b0;
        ld0_read  = 1'b0;
        ld1_addr  = '0;
        ld1_size  = '0;
        ld1_sign  = 1'b0;
        ld1_read  = 1'b0;
        st0_addr  = '0;
        st0_data  = '0;
        st0_size  = '0;
        st0_write = 1'b0;
        st1_addr  = '0;
        st1_data  = '0;
        st1_size  = '0;
        st1_write = 1'b0;
    endtask

    task automatic apply_access(input int i);
        mem_cfg_pkg::word_t wdata;
        wdata = data_q[i];
        if (op_q[i] == OP_FILLER)
        begin
            wdata = $urandom;
            $display("filler %08h at %08h on store lane %0d", wdata, addr_q[i], lane_q[i]);
        end
        if (op_q[i] == OP_LOAD && lane_q[i] == 0)
        begin
            ld0_addr = addr_q[i];
            ld0_size = size_q[i];
            ld0_sign = sign_q[i];
            ld0_read = 1'b1;
            exp0_q.push_back(data_q[i]);
            where0_q.push_back(addr_q[i]);
        end
        else if (op_q[i] == OP_LOAD)
        begin
            ld1_addr = addr_q[i];
            ld1_size = size_q[i];
            ld1_sign = sign_q[i];
            ld1_read = 1'b1;
            exp1_q.push_back(data_q[i]);
            where1_q.push_back(addr_q[i]);
        end
        else if (lane_q[i] == 0)
        begin
            st0_addr  = addr_q[i];
            st0_data  = wdata;
            st0_size  = size_q[i];
            st0_write = 1'b1;
        end
        else
        begin
            st1_addr  = addr_q[i];
            st1_data  = wdata;
            st1_size  = size_q[i];
            st1_write = 1'b1;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // result monitor sampled mid cycle where outputs are settled

    task automatic check_load_lane(input int lane, input logic valid, input logic was_read,
                                   input mem_cfg_pkg::word_t data);
        mem_cfg_pkg::word_t expected;
        mem_cfg_pkg::addr_t where;
        check_value(mem_cfg_pkg::word_t'(valid), mem_cfg_pkg::word_t'(was_read),
                    $sformatf("ld%0d_valid one cycle after ld%0d_read", lane, lane));
        if (valid)
        begin
            if (lane == 0)
            begin
                expected = exp0_q.pop_front();
                where    = where0_q.pop_front();
            end
            else
            begin
                expected = exp1_q.pop_front();
                where    = where1_q.pop_front();
            end
            check_value(data, expected, $sformatf("ld%0d_data at %08h", lane, where));
        end
    endtask

    always @(posedge MEM_CLK)
    begin
        read_seen_0 = ld0_read & rst_n;   // no valid for a strobe seen in reset
        read_seen_1 = ld1_read & rst_n;
    end

    // first check after the first rising edge
    initial
    begin : result_monitor
        @(posedge MEM_CLK);
        forever
        begin
            @(negedge MEM_CLK);
            check_load_lane(0, ld0_valid, read_seen_0, ld0_data);
            check_load_lane(1, ld1_valid, read_seen_1, ld1_data);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence with one stimulus group per clock cycle

    initial
    begin : main_flow
        int unused_seed;
        int i;
        int cycle;
        int drain;
        read_seen_0 = 1'b0;
        read_seen_1 = 1'b0;
        drive_idle();
        ld0_read = 1'b1;                  // strobes held through reset must be ignored
        ld1_read = 1'b1;
        unused_seed = $urandom(SEED);     // seeds this process once
        load_stimulus();
        if (grp_q.size() == 0)
        begin
            $display("the stimulus file %s holds no accesses", STIM_FILE);
            fail_and_stop();
        end
        loaded = 1'b1;
        $display("%0d accesses read from %s", grp_q.size(), STIM_FILE);

        repeat (RESET_CYCLES - 1) @(posedge MEM_CLK);
        #(DRIVE_DELAY);
        drive_idle();                     // strobes dropped before reset release
        @(posedge rst_n);
        @(posedge MEM_CLK);
        i     = 0;
        cycle = grp_q[0];
        while (i < grp_q.size())
        begin
            #(DRIVE_DELAY);
            drive_idle();
            while (i < grp_q.size() && grp_q[i] == cycle)
            begin
                apply_access(i);
                i++;
            end
            if (i < grp_q.size() && grp_q[i] < cycle)
            begin
                $display("stimulus groups out of order at access %0d", i);
                fail_and_stop();
            end
            cycle++;                      // gaps in group numbers give idle cycles
            @(posedge MEM_CLK);
        end
        #(DRIVE_DELAY);
        drive_idle();

        drain = 0;
        while ((exp0_q.size() != 0 || exp1_q.size() != 0) && drain < DRAIN_CYCLES)
        begin
            @(posedge MEM_CLK);
            drain++;
        end
        if (exp0_q.size() != 0 || exp1_q.size() != 0)
        begin
            $display("load valid never came for %0d lane 0 and %0d lane 1 loads",
                     exp0_q.size(), exp1_q.size());
            fail_and_stop();
        end
        else
        begin
            $display("all tests passed");
            $finish;
        end
    end

    // watchdog sized from the number of accesses
    initial
    begin : watchdog
        longint limit_ns;
        wait (loaded);
        limit_ns = longint'(grp_q.size() * CYCLES_PER_LINE + RESET_CYCLES) * CLK_PERIOD;
        #(limit_ns);
        $display("watchdog expired after %0d ns and the run did not finish", limit_ns);
        fail_and_stop();
    end

endmodule

// ==== bench/lsu_stimulus.txt ====
# grp lane op sz sgn addr data, one cycle per group number, gaps are idle cycles
# op 0 load (data = expected result), 1 store, 2 random filler store; sz 0 byte 1 half 2 word 3 bad
1  0 2 2 0 00000100 00000000
1  1 2 2 0 00000104 00000000
2  0 1 2 0 00000100 11223344
2  1 1 2 0 00000104 a5a55a5a
3  0 0 2 0 00000100 11223344
3  1 0 2 1 00000104 a5a55a5a
4  0 0 2 1 00000104 a5a55a5a
4  1 0 2 0 00000100 11223344
6  0 1 0 0 00000108 00000081
6  1 1 0 0 00000109 0000007f
7  0 1 0 0 0000010a 123456c3
7  1 1 0 0 0000010b 00000042
8  0 0 2 0 00000108 42c37f81
9  0 0 0 1 00000108 ffffff81
9  1 0 0 0 00000109 0000007f
10 0 0 0 1 0000010a ffffffc3
10 1 0 0 1 0000010b 00000042
11 0 0 0 0 0000010a 000000c3
13 0 1 1 0 0000010c dead8001
13 1 1 1 0 0000010e 00007ffe
14 0 0 1 1 0000010c ffff8001
14 1 0 1 0 0000010c 00008001
15 0 0 1 1 0000010e 00007ffe
15 1 0 1 0 0000010e 00007ffe
16 0 1 1 0 0000010d 1234ffff
16 1 1 2 0 0000010e ffffffff
17 0 1 2 0 0000010f ffffffff
17 1 1 3 0 0000010c ffffffff
18 0 0 2 0 0000010c 7ffe8001
18 1 0 1 1 0000010d 00000000
19 0 0 2 0 0000010e 00000000
19 1 0 3 1 0000010c 00000000
21 0 1 1 0 00000110 0000beef
21 1 1 1 0 00000112 0000cafe
22 0 0 2 0 00000110 cafebeef
23 0 1 2 0 00000110 11111111
23 1 1 0 0 00000111 000000ee
24 1 0 2 0 00000110 1111ee11
25 0 1 0 0 00000113 00000055
25 1 1 1 0 00000112 0000aa77
26 0 0 2 0 00000110 aa77ee11
27 0 1 2 0 00000114 01010101
27 1 1 2 0 00000114 02020202
28 1 0 2 0 00000114 02020202
30 0 0 2 0 00000100 11223344
30 1 0 2 0 00000104 a5a55a5a
31 0 0 0 0 00000108 00000081
31 1 0 1 0 0000010c 00008001
32 0 0 2 0 00000110 aa77ee11
32 1 0 2 0 00000114 02020202
33 0 1 2 0 00000100 99887766
33 0 0 2 0 00000100 11223344
33 1 1 0 0 00000104 000000ff
33 1 0 2 0 00000104 a5a55a5a
34 0 0 2 0 00010100 99887766
34 1 0 2 0 00000104 a5a55aff

// ==== flist.f ====
hw/mem_cfg_pkg.sv
hw/mem_op_pkg.sv
hw/store_align.sv
hw/data_array.sv
hw/load_extract.sv
hw/lsu_data_mem.sv
bench/tb_clock_gen.sv
bench/tb_lsu_data_mem.sv

// ==== Bender.yml ====
package:
  name: lsu_data_mem

sources:
  # packages first, then the design
  - files:
      - hw/mem_cfg_pkg.sv
      - hw/mem_op_pkg.sv
      - hw/store_align.sv
      - hw/data_array.sv
      - hw/load_extract.sv
      - hw/lsu_data_mem.sv

  # testbench, top module tb_lsu_data_mem
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_lsu_data_mem.sv
